// File: src/burst_split_config.svh
`ifndef BURST_SPLIT_CONFIG_SVH
`define BURST_SPLIT_CONFIG_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------

// Address bits on both AR ports
`define BS_ADDR_WIDTH 32

// Data bits on both R ports
`define BS_DATA_WIDTH 32

// ------------------------------------------------------------
// Outstanding upstream read bursts, one beat slot each
// ------------------------------------------------------------
`define BS_NUM_SLOTS 4

`endif

// File: src/burst_split_pkg.sv
`include "burst_split_config.svh"
`default_nettype none

package burst_split_pkg;

  localparam int unsigned SLOT_IDX_W = (`BS_NUM_SLOTS > 1) ? $clog2(`BS_NUM_SLOTS) : 1;

  typedef logic [`BS_ADDR_WIDTH-1:0] addr_t;
  typedef logic [7:0]                len_t;
  // Beats minus one never exceeds 255, so 256 beats need one extra bit
  typedef logic [8:0]                beats_t;
  typedef logic [2:0]                size_t;
  typedef logic [SLOT_IDX_W-1:0]     slot_idx_t;

  // WRAP is not accepted by the splitter
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01
  } burst_e;

  typedef enum logic {SPLIT_IDLE, SPLIT_BUSY} split_state_e;
  typedef enum logic {MERGE_PASS, MERGE_HOLD} merge_state_e;

  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } ar_chan_t;

  typedef struct packed {
    logic [`BS_DATA_WIDTH-1:0] data;
    logic [1:0]                resp;
    logic                      last;
  } r_chan_t;

  // Load comes from the AR side, dec from the R side
  typedef struct packed {
    logic   load;
    beats_t load_beats;
    logic   dec;
    beats_t delta;
  } slot_cmd_t;

  // Ring pointer step
  function automatic slot_idx_t next_slot(slot_idx_t idx);
    if (idx == slot_idx_t'(`BS_NUM_SLOTS - 1)) begin
      return '0;
    end
    return idx + slot_idx_t'(1);
  endfunction

endpackage

`default_nettype wire

// File: src/beat_slot.sv
`default_nettype none

module beat_slot (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  burst_split_pkg::slot_cmd_t  cmd_i,
  output burst_split_pkg::beats_t     count_o,
  output logic                        busy_o
);

  import burst_split_pkg::*;

  // Upstream beats still owed for this burst
  beats_t count_q;

  // ------------------------------------------------------------
  // Counter
  // ------------------------------------------------------------
  // A load only ever targets an idle slot, so it cannot collide
  // with a decrement of live data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (cmd_i.load) begin
      count_q <= cmd_i.load_beats;
    end else if (cmd_i.dec) begin
      // The remainder sub-burst carries fewer than delta beats
      if (count_q > cmd_i.delta) begin
        count_q <= count_q - cmd_i.delta;
      end else begin
        count_q <= '0;
      end
    end
  end

  assign count_o = count_q;
  assign busy_o  = (count_q != '0);

endmodule

`default_nettype wire

// File: src/ar_splitter.sv
`include "burst_split_config.svh"
`default_nettype none

module ar_splitter (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  burst_split_pkg::len_t       len_limit_i,
  input  burst_split_pkg::ar_chan_t   up_ar_i,
  input  logic                        up_ar_valid_i,
  output logic                        up_ar_ready_o,
  output burst_split_pkg::ar_chan_t   dn_ar_o,
  output logic                        dn_ar_valid_o,
  input  logic                        dn_ar_ready_i,
  input  logic [`BS_NUM_SLOTS-1:0]    slot_busy_i,
  output burst_split_pkg::slot_cmd_t  slot_cmd_o,
  output burst_split_pkg::slot_idx_t  wr_idx_o
);

  import burst_split_pkg::*;

  split_state_e state_q, state_d;
  ar_chan_t     ar_q, ar_d;
  beats_t       beats_q, beats_d;
  slot_idx_t    wr_idx_q, wr_idx_d;
  beats_t       max_beats;
  beats_t       up_beats;
  logic         last_sub;

  // Start of the next sub-burst for INCR, the same address for FIXED
  function automatic addr_t next_addr(ar_chan_t ar, beats_t step);
    addr_t unit;
    addr_t aligned;
    unit    = addr_t'(1) << ar.size;
    aligned = ar.addr & ~(unit - addr_t'(1));
    if (ar.burst == BURST_INCR) begin
      return aligned + unit * addr_t'(step);
    end
    return ar.addr;
  endfunction

  // A limit of 0 means single-beat sub-bursts
  assign max_beats = {1'b0, len_limit_i} + 9'd1;
  assign up_beats  = {1'b0, up_ar_i.len} + 9'd1;
  assign last_sub  = (beats_q <= max_beats);
  assign wr_idx_o  = wr_idx_q;

  // ------------------------------------------------------------
  // Split FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    ar_d          = ar_q;
    beats_d       = beats_q;
    wr_idx_d      = wr_idx_q;
    up_ar_ready_o = 1'b0;
    dn_ar_o       = up_ar_i;
    dn_ar_valid_o = 1'b0;
    slot_cmd_o    = '0;
    slot_cmd_o.load_beats = up_beats;

    case (state_q)
      SPLIT_IDLE: begin
        if (up_ar_valid_i && !slot_busy_i[wr_idx_q]) begin
          dn_ar_valid_o = 1'b1;
          if (up_ar_i.len <= len_limit_i) begin
            // Short enough, pass through and wait for downstream
            if (dn_ar_ready_i) begin
              up_ar_ready_o   = 1'b1;
              slot_cmd_o.load = 1'b1;
              wr_idx_d        = next_slot(wr_idx_q);
            end
          end else begin
            // Take the burst now and offer the first piece
            dn_ar_o.len     = len_limit_i;
            up_ar_ready_o   = 1'b1;
            slot_cmd_o.load = 1'b1;
            wr_idx_d        = next_slot(wr_idx_q);
            state_d         = SPLIT_BUSY;
            ar_d            = up_ar_i;
            beats_d         = up_beats;
            if (dn_ar_ready_i) begin
              beats_d   = up_beats - max_beats;
              ar_d.addr = next_addr(up_ar_i, max_beats);
            end
          end
        end
      end

      SPLIT_BUSY: begin
        dn_ar_o       = ar_q;
        dn_ar_valid_o = 1'b1;
        // Remainder length on the final piece
        if (last_sub) begin
          dn_ar_o.len = len_t'(beats_q - 9'd1);
        end else begin
          dn_ar_o.len = len_limit_i;
        end
        if (dn_ar_ready_i) begin
          if (last_sub) begin
            state_d = SPLIT_IDLE;
          end else begin
            beats_d   = beats_q - max_beats;
            ar_d.addr = next_addr(ar_q, max_beats);
          end
        end
      end

      default: begin
        state_d = SPLIT_IDLE;
      end
    endcase
  end

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= SPLIT_IDLE;
      beats_q  <= '0;
      wr_idx_q <= '0;
    end else begin
      state_q  <= state_d;
      beats_q  <= beats_d;
      wr_idx_q <= wr_idx_d;
    end
  end

  // Stored request, only read in SPLIT_BUSY
  always_ff @(posedge clk_i) begin
    ar_q <= ar_d;
  end

endmodule

`default_nettype wire

// File: src/r_last_merger.sv
`include "burst_split_config.svh"
`default_nettype none

module r_last_merger (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  burst_split_pkg::len_t                         len_limit_i,
  input  burst_split_pkg::r_chan_t                      dn_r_i,
  input  logic                                          dn_r_valid_i,
  output logic                                          dn_r_ready_o,
  output burst_split_pkg::r_chan_t                      up_r_o,
  output logic                                          up_r_valid_o,
  input  logic                                          up_r_ready_i,
  input  burst_split_pkg::beats_t [`BS_NUM_SLOTS-1:0]   slot_count_i,
  output burst_split_pkg::slot_cmd_t                    slot_cmd_o,
  output burst_split_pkg::slot_idx_t                    rd_idx_o
);

  import burst_split_pkg::*;

  merge_state_e state_q, state_d;
  logic         last_q, last_d;
  slot_idx_t    rd_idx_q, rd_idx_d;
  beats_t       max_beats;
  beats_t       cur_count;

  assign max_beats = {1'b0, len_limit_i} + 9'd1;
  // Responses come back in order, so the oldest slot owns this beat
  assign cur_count = slot_count_i[rd_idx_q];
  assign rd_idx_o  = rd_idx_q;

  // ------------------------------------------------------------
  // Last reconstruction
  // ------------------------------------------------------------
  always_comb begin
    state_d          = state_q;
    last_d           = last_q;
    rd_idx_d         = rd_idx_q;
    up_r_o           = dn_r_i;
    up_r_o.last      = 1'b0;
    up_r_valid_o     = 1'b0;
    dn_r_ready_o     = 1'b0;
    slot_cmd_o       = '0;
    slot_cmd_o.delta = max_beats;

    case (state_q)
      MERGE_PASS: begin
        if (dn_r_valid_i) begin
          up_r_valid_o = 1'b1;
          if (dn_r_i.last) begin
            // End of a sub-burst, the burst ends once the slot runs dry
            last_d         = (cur_count <= max_beats);
            slot_cmd_o.dec = 1'b1;
            if (last_d) begin
              rd_idx_d = next_slot(rd_idx_q);
            end
          end else begin
            last_d = 1'b0;
          end
          up_r_o.last = last_d;
          if (up_r_ready_i) begin
            dn_r_ready_o = 1'b1;
          end else begin
            state_d = MERGE_HOLD;
          end
        end
      end

      MERGE_HOLD: begin
        // Slot already decremented, replay the stored decision
        up_r_o.last  = last_q;
        up_r_valid_o = dn_r_valid_i;
        if (dn_r_valid_i && up_r_ready_i) begin
          dn_r_ready_o = 1'b1;
          state_d      = MERGE_PASS;
        end
      end

      default: begin
        state_d = MERGE_PASS;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= MERGE_PASS;
      last_q   <= 1'b0;
      rd_idx_q <= '0;
    end else begin
      state_q  <= state_d;
      last_q   <= last_d;
      rd_idx_q <= rd_idx_d;
    end
  end

endmodule

`default_nettype wire

// File: src/burst_splitter.sv
`include "burst_split_config.svh"
`default_nettype none

module burst_splitter (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  burst_split_pkg::len_t      len_limit_i,
  // Upstream
  input  burst_split_pkg::ar_chan_t  up_ar_i,
  input  logic                       up_ar_valid_i,
  output logic                       up_ar_ready_o,
  output burst_split_pkg::r_chan_t   up_r_o,
  output logic                       up_r_valid_o,
  input  logic                       up_r_ready_i,
  // Downstream
  output burst_split_pkg::ar_chan_t  dn_ar_o,
  output logic                       dn_ar_valid_o,
  input  logic                       dn_ar_ready_i,
  input  burst_split_pkg::r_chan_t   dn_r_i,
  input  logic                       dn_r_valid_i,
  output logic                       dn_r_ready_o
);

  import burst_split_pkg::*;

  slot_cmd_t                      load_cmd;
  slot_cmd_t                      dec_cmd;
  slot_idx_t                      wr_idx;
  slot_idx_t                      rd_idx;
  slot_cmd_t [`BS_NUM_SLOTS-1:0]  slot_cmd;
  beats_t [`BS_NUM_SLOTS-1:0]     slot_count;
  logic [`BS_NUM_SLOTS-1:0]       slot_busy;

  ar_splitter u_ar_splitter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .len_limit_i   (len_limit_i),
    .up_ar_i       (up_ar_i),
    .up_ar_valid_i (up_ar_valid_i),
    .up_ar_ready_o (up_ar_ready_o),
    .dn_ar_o       (dn_ar_o),
    .dn_ar_valid_o (dn_ar_valid_o),
    .dn_ar_ready_i (dn_ar_ready_i),
    .slot_busy_i   (slot_busy),
    .slot_cmd_o    (load_cmd),
    .wr_idx_o      (wr_idx)
  );

  // ------------------------------------------------------------
  // Beat slot ring
  // ------------------------------------------------------------
  for (genvar i = 0; i < `BS_NUM_SLOTS; i++) begin : gen_slot
    // Load from the write pointer, decrement from the read pointer
    assign slot_cmd[i] = '{
      load:       load_cmd.load && (wr_idx == slot_idx_t'(i)),
      load_beats: load_cmd.load_beats,
      dec:        dec_cmd.dec && (rd_idx == slot_idx_t'(i)),
      delta:      dec_cmd.delta
    };

    beat_slot u_beat_slot (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .cmd_i   (slot_cmd[i]),
      .count_o (slot_count[i]),
      .busy_o  (slot_busy[i])
    );
  end

  r_last_merger u_r_last_merger (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .len_limit_i  (len_limit_i),
    .dn_r_i       (dn_r_i),
    .dn_r_valid_i (dn_r_valid_i),
    .dn_r_ready_o (dn_r_ready_o),
    .up_r_o       (up_r_o),
    .up_r_valid_o (up_r_valid_o),
    .up_r_ready_i (up_r_ready_i),
    .slot_count_i (slot_count),
    .slot_cmd_o   (dec_cmd),
    .rd_idx_o     (rd_idx)
  );

endmodule

`default_nettype wire

// File: testbench/burst_split_assertions.sv
`default_nettype none

module burst_split_assertions (
  input logic                       clk_i,
  input logic                       rst_i,
  input burst_split_pkg::len_t      len_limit_i,
  input burst_split_pkg::ar_chan_t  dn_ar_o,
  input logic                       dn_ar_valid_o,
  input logic                       dn_ar_ready_i,
  input burst_split_pkg::r_chan_t   up_r_o,
  input logic                       up_r_valid_o,
  input logic                       up_r_ready_i
);

  // Number of failed assertions, read out at the end of the run
  int fail_count = 0;

  // No sub-burst is longer than the runtime limit
  dn_ar_len_limited: assert property (
    @(posedge clk_i) disable iff (rst_i)
    dn_ar_valid_o |-> (dn_ar_o.len <= len_limit_i)
  ) else begin
    fail_count++;
    $error("Downstream AR len %0d above limit %0d", dn_ar_o.len, len_limit_i);
  end

  // Downstream AR holds while stalled
  dn_ar_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    dn_ar_valid_o && !dn_ar_ready_i |=> dn_ar_valid_o && $stable(dn_ar_o)
  ) else begin
    fail_count++;
    $error("Downstream AR changed or dropped while stalled");
  end

  // Upstream R holds while stalled, last included
  up_r_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    up_r_valid_o && !up_r_ready_i |=> up_r_valid_o && $stable(up_r_o)
  ) else begin
    fail_count++;
    $error("Upstream R changed or dropped while stalled");
  end

endmodule

bind burst_splitter burst_split_assertions u_assertions (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .len_limit_i   (len_limit_i),
  .dn_ar_o       (dn_ar_o),
  .dn_ar_valid_o (dn_ar_valid_o),
  .dn_ar_ready_i (dn_ar_ready_i),
  .up_r_o        (up_r_o),
  .up_r_valid_o  (up_r_valid_o),
  .up_r_ready_i  (up_r_ready_i)
);

`default_nettype wire

// File: testbench/tb_burst_splitter.sv
`default_nettype none

module tb_burst_splitter;

  import burst_split_pkg::*;

  localparam int MAX_TESTS = 64;

  logic     clk_i, rst_i;
  len_t     len_limit_i;
  ar_chan_t up_ar_i, dn_ar_o;
  r_chan_t  up_r_o, dn_r_i;
  logic     up_ar_valid_i, up_ar_ready_o, up_r_valid_o, up_r_ready_i;
  logic     dn_ar_valid_o, dn_ar_ready_i, dn_r_valid_i, dn_r_ready_o;

  // Test table from the data file
  string    test_name [MAX_TESTS];
  len_t     test_limit [MAX_TESTS];
  ar_chan_t test_ar [MAX_TESTS];
  int       num_tests, total_beats;

  // Expected traffic in issue order
  ar_chan_t exp_ar_q[$];
  int       exp_ar_test_q[$];
  addr_t    exp_data_q[$];
  logic     exp_last_q[$];
  int       exp_r_test_q[$];

  // Downstream memory model
  ar_chan_t mem_q[$];
  ar_chan_t cur_sub;
  int       cur_beat;
  logic     sub_active;

  int ar_errors, r_errors, other_errors;

  burst_splitter i_dut (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // AXI beat address, the first beat keeps its misalignment
  function automatic addr_t beat_addr(ar_chan_t ar, int idx);
    addr_t unit;
    unit = addr_t'(1) << ar.size;
    if (ar.burst == BURST_FIXED || idx == 0) begin
      return ar.addr;
    end
    return (ar.addr & ~(unit - addr_t'(1))) + unit * addr_t'(idx);
  endfunction

  // Response code the memory model attaches to a beat address
  function automatic logic [1:0] beat_resp(addr_t addr);
    return addr[5:4];
  endfunction

  task automatic read_tests();
    int    fd;
    int    n, limit, len, size, burst;
    string line, name;
    addr_t addr;
    fd = $fopen("testbench/burst_split_tests.txt", "r");
    num_tests   = 0;
    total_beats = 0;
    assert (fd != 0) else begin
      other_errors++;
      $display("Could not open testbench/burst_split_tests.txt");
    end
    while (fd != 0 && !$feof(fd) && num_tests < MAX_TESTS) begin
      n = $fgets(line, fd);
      // Skip blank and comment lines
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %d %h %d %d %d", name, limit, addr, len, size, burst);
        if (n == 6) begin
          test_name[num_tests]     = name;
          test_limit[num_tests]    = len_t'(limit);
          test_ar[num_tests].addr  = addr;
          test_ar[num_tests].len   = len_t'(len);
          test_ar[num_tests].size  = size_t'(size);
          test_ar[num_tests].burst = (burst == 0) ? BURST_FIXED : BURST_INCR;
          total_beats += len + 1;
          num_tests++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
  endtask

  // Sub-bursts and upstream beats that one test must produce
  task automatic push_expected(int t);
    ar_chan_t sub;
    int       beats, step, pos;
    beats = int'(test_ar[t].len) + 1;
    step  = int'(test_limit[t]) + 1;
    for (pos = 0; pos < beats; pos += step) begin
      sub      = test_ar[t];
      sub.addr = beat_addr(test_ar[t], pos);
      sub.len  = len_t'(((beats - pos > step) ? step : beats - pos) - 1);
      exp_ar_q.push_back(sub);
      exp_ar_test_q.push_back(t);
    end
    for (pos = 0; pos < beats; pos++) begin
      exp_data_q.push_back(beat_addr(test_ar[t], pos));
      exp_last_q.push_back(pos == beats - 1);
      exp_r_test_q.push_back(t);
    end
  endtask

  initial begin
    int       cycle, timeout_limit, next_test, t;
    logic     ar_pending, dn_r_fire, finished;
    ar_chan_t exp_ar;
    void'($urandom(32'hba65_20e5));
    ar_errors     = 0;
    r_errors      = 0;
    other_errors  = 0;
    rst_i         = 1'b1;
    len_limit_i   = '0;
    up_ar_i       = '0;
    up_ar_valid_i = 1'b0;
    up_r_ready_i  = 1'b0;
    dn_ar_ready_i = 1'b0;
    dn_r_i        = '0;
    dn_r_valid_i  = 1'b0;
    cur_sub       = '0;
    cur_beat      = 0;
    sub_active    = 1'b0;
    read_tests();
    assert (num_tests > 0) else begin
      other_errors++;
      $display("No tests found in the test file");
    end
    if (num_tests > 0) begin
      len_limit_i = test_limit[0];
    end
    timeout_limit = 64 * total_beats + 200;
    next_test     = 0;
    ar_pending    = 1'b0;
    cycle         = 0;
    finished      = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    while (!finished && cycle < timeout_limit) begin
      @(posedge clk_i);
      cycle++;
      // ----------------------------------------------------------
      // Handshakes seen by the DUT on this edge
      // ----------------------------------------------------------
      if (up_ar_valid_i && up_ar_ready_o) begin
        push_expected(next_test);
        next_test++;
        ar_pending = 1'b0;
      end
      if (dn_ar_valid_o && dn_ar_ready_i) begin
        mem_q.push_back(dn_ar_o);
        assert (exp_ar_q.size() > 0) else begin
          other_errors++;
          $display("Downstream AR at %h issued with no sub-burst expected", dn_ar_o.addr);
        end
        if (exp_ar_q.size() > 0) begin
          exp_ar = exp_ar_q.pop_front();
          t      = exp_ar_test_q.pop_front();
          // Fields shown as addr/len/size/burst
          assert (dn_ar_o == exp_ar) else begin
            ar_errors++;
            $display("CHECK FAILED %s: dn_ar expected %h/%0d/%0d/%0d, actual %h/%0d/%0d/%0d",
                     test_name[t], exp_ar.addr, exp_ar.len, exp_ar.size, exp_ar.burst,
                     dn_ar_o.addr, dn_ar_o.len, dn_ar_o.size, dn_ar_o.burst);
          end
        end
      end
      if (up_r_valid_o && up_r_ready_i) begin
        assert (exp_data_q.size() > 0) else begin
          other_errors++;
          $display("Upstream R beat %h arrived with no beat expected", up_r_o.data);
        end
        if (exp_data_q.size() > 0) begin
          t = exp_r_test_q.pop_front();
          assert (up_r_o.data == exp_data_q[0] && up_r_o.last == exp_last_q[0] &&
                  up_r_o.resp == beat_resp(exp_data_q[0])) else begin
            r_errors++;
            $display("CHECK FAILED %s: up_r data/resp/last expected %h/%0d/%b, actual %h/%0d/%b",
                     test_name[t], exp_data_q[0], beat_resp(exp_data_q[0]), exp_last_q[0],
                     up_r_o.data, up_r_o.resp, up_r_o.last);
          end
          exp_data_q.delete(0);
          exp_last_q.delete(0);
        end
      end
      dn_r_fire = dn_r_valid_i && dn_r_ready_o;
      if (dn_r_fire) begin
        cur_beat++;
        sub_active = (cur_beat <= int'(cur_sub.len));
      end

      #1;
      // ----------------------------------------------------------
      // New input values
      // ----------------------------------------------------------
      // The limit only moves while nothing is outstanding
      if (!ar_pending && next_test < num_tests) begin
        if (exp_data_q.size() == 0 && exp_ar_q.size() == 0) begin
          len_limit_i = test_limit[next_test];
        end
        if (len_limit_i == test_limit[next_test]) begin
          up_ar_i    = test_ar[next_test];
          ar_pending = 1'b1;
        end
      end
      up_ar_valid_i = ar_pending;
      if (!sub_active && mem_q.size() > 0) begin
        cur_sub    = mem_q.pop_front();
        cur_beat   = 0;
        sub_active = 1'b1;
      end
      // A presented beat stays until it is taken
      if (dn_r_fire || !dn_r_valid_i) begin
        dn_r_valid_i = sub_active && ($urandom % 4 != 0);
        dn_r_i.data  = beat_addr(cur_sub, cur_beat);
        dn_r_i.resp  = beat_resp(beat_addr(cur_sub, cur_beat));
        dn_r_i.last  = (cur_beat == int'(cur_sub.len));
      end
      dn_ar_ready_i = ($urandom % 4 != 0);
      up_r_ready_i  = ($urandom % 4 != 0);
      finished = (next_test == num_tests) && !ar_pending && !sub_active &&
                 exp_ar_q.size() == 0 && exp_data_q.size() == 0 && mem_q.size() == 0;
    end

    if (!finished) begin
      other_errors++;
      $display("Timeout after %0d cycles with %0d upstream beats still outstanding",
               cycle, exp_data_q.size());
    end
    $display("Errors: dn_ar %0d, up_r %0d, other %0d, assertion %0d",
             ar_errors, r_errors, other_errors, i_dut.u_assertions.fail_count);
    if (ar_errors + r_errors + other_errors + i_dut.u_assertions.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/burst_split_tests.txt
# name limit(dec) addr(hex) len(dec) size(dec) burst(0 is FIXED and 1 is INCR)
# Consecutive tests with the same limit are issued back to back
pass_single       3  00001000    0  2  1
pass_at_limit     3  00001100    3  2  1
pass_fixed        3  00001200    2  2  0
split_incr_even   3  00002000   15  2  1
split_incr_rem    3  00003000    9  2  1
split_unaligned   3  00003102    6  2  1
split_fixed       3  00004000   10  2  0
limit0_incr       0  00005000    3  2  1
limit0_fixed      0  00005100    2  1  0
limit0_byte       0  00005203    4  0  1
max_len_split    15  00006000  255  2  1
pass_long        15  00007000   15  3  1
ring_a            1  00008000    4  2  1
ring_b            1  00008100    1  2  1
ring_c            1  00008200    6  1  1
ring_d            1  00008300    3  2  0
ring_e            1  00008400    7  2  1
ring_f            1  00008500    0  0  1
ring_g            1  0000860a    5  1  1
full_pass       255  00009000  255  2  1

// File: burst_split.f
+incdir+src
src/burst_split_pkg.sv
src/beat_slot.sv
src/ar_splitter.sv
src/r_last_merger.sv
src/burst_splitter.sv
testbench/burst_split_assertions.sv
testbench/tb_burst_splitter.sv
